// File: design/sampler_pkg.sv
`default_nettype none

package sampler_pkg;

    // **********************************************************************
    // Instrument map and widths.
    // **********************************************************************

    localparam int INSTRUMENT_COUNT = 3;

    // Entry i is the MIDI key that triggers instrument i.
    localparam logic [INSTRUMENT_COUNT-1:0][6:0] MIDI_KEYS = {7'd64, 7'd62, 7'd60};

    localparam int ADDR_WIDTH     = 24;
    localparam int PERIOD_WIDTH   = 14;
    localparam int INSTR_ID_WIDTH = 2;

    // Short bit time for simulation. Hardware needs clk_hz / 31250 here.
    localparam int MIDI_BIT_CYCLES = 16;

    localparam int FIFO_DEPTH = 16;

    // **********************************************************************
    // Shared types.
    // **********************************************************************

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]     addr;
        logic [INSTR_ID_WIDTH-1:0] instr;
        logic                      last;  // Final address of the sample.
    } read_req_t;

    // Region i spans entry i up to, but not including, entry i+1.
    typedef logic [INSTRUMENT_COUNT:0][ADDR_WIDTH-1:0] addr_table_t;

endpackage

`default_nettype wire

// File: design/midi_processor.sv
`timescale 1ns/100ps
`default_nettype none

module midi_processor
    import sampler_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        din,
    output logic       note_on,
    output logic [6:0] key,
    output logic [6:0] velocity
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
    typedef enum logic [1:0] {P_STATUS, P_KEY, P_VEL} parse_state_t;

    logic [1:0] din_sync;
    logic       din_s;

    rx_state_t                          rx_state;
    logic [$clog2(MIDI_BIT_CYCLES)-1:0] tick_cnt;
    logic [2:0]                         bit_idx;
    logic [7:0]                         shift;
    logic                               byte_valid;

    parse_state_t parse_state;

    // **********************************************************************
    // Byte receiver.
    // **********************************************************************

    always_ff @(posedge clk) begin
        din_sync <= {din_sync[0], din};
    end

    assign din_s = din_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state   <= RX_IDLE;
            tick_cnt   <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!din_s) rx_state <= RX_START;  // Falling edge of the start bit.
                end
                RX_START: begin
                    if (int'(tick_cnt) == MIDI_BIT_CYCLES / 2 - 1) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        rx_state <= din_s ? RX_IDLE : RX_DATA;  // A glitch goes back to idle.
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (int'(tick_cnt) == MIDI_BIT_CYCLES - 1) begin
                        tick_cnt <= '0;
                        shift    <= {din_s, shift[7:1]};  // LSB arrives first.
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) rx_state <= RX_STOP;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    if (int'(tick_cnt) == MIDI_BIT_CYCLES - 1) begin
                        tick_cnt   <= '0;
                        rx_state   <= RX_IDLE;
                        byte_valid <= din_s;  // Framing errors are dropped.
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // **********************************************************************
    // Note-on parser.
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            parse_state <= P_STATUS;
            note_on     <= 1'b0;
        end else begin
            note_on <= 1'b0;
            if (byte_valid) begin
                if (shift[7]) begin
                    parse_state <= (shift[7:4] == 4'h9) ? P_KEY : P_STATUS;
                end else begin
                    case (parse_state)
                        P_KEY: begin
                            key         <= shift[6:0];
                            parse_state <= P_VEL;
                        end
                        P_VEL: begin
                            velocity    <= shift[6:0];
                            note_on     <= (shift[6:0] != 7'd0);  // Zero velocity is a note-off.
                            parse_state <= P_STATUS;
                        end
                        default: parse_state <= P_STATUS;
                    endcase
                end
            end
        end
    end

    // Three bytes separate any two note-ons.
    a_note_on_single: assert property (@(posedge clk) disable iff (rst) note_on |=> !note_on);

endmodule

`default_nettype wire

// File: design/instrument.sv
`timescale 1ns/100ps
`default_nettype none

module instrument
    import sampler_pkg::*;
#(
    parameter logic [6:0] MIDI_KEY = 7'd60
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [PERIOD_WIDTH-1:0]   sample_period,
    input  wire                      note_on,
    input  wire [6:0]                key,
    input  wire                      setup_complete,
    input  wire [ADDR_WIDTH-1:0]     addr_start,
    input  wire [ADDR_WIDTH-1:0]     addr_stop,
    input  wire [INSTR_ID_WIDTH-1:0] instr_id,
    output read_req_t                addr,
    output logic                     addr_valid,
    input  wire                      addr_take
);

    logic                    playing;
    logic [ADDR_WIDTH-1:0]   cur_addr;
    logic [PERIOD_WIDTH-1:0] period_cnt;
    logic                    trigger;
    logic                    period_done;
    logic                    is_last;

    assign trigger     = note_on && (key == MIDI_KEY) && setup_complete;
    assign period_done = (period_cnt >= sample_period - 1'b1);
    assign is_last     = (cur_addr == addr_stop - 1'b1);

    always_comb begin
        addr.addr  = cur_addr;
        addr.instr = instr_id;
        addr.last  = is_last;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            playing    <= 1'b0;
            addr_valid <= 1'b0;
            period_cnt <= '0;
        end else if (trigger) begin
            playing    <= 1'b1;  // Restart from the beginning, even mid-sample.
            addr_valid <= 1'b0;
            period_cnt <= '0;
        end else if (addr_valid) begin
            if (addr_take) begin
                addr_valid <= 1'b0;
                if (is_last) playing <= 1'b0;
            end
        end else if (playing) begin
            if (period_done) begin
                addr_valid <= 1'b1;
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    // The address only moves on a restart or once the scanner has taken it.
    always_ff @(posedge clk) begin
        if (trigger) begin
            cur_addr <= addr_start;
        end else if (addr_valid && addr_take && !is_last) begin
            cur_addr <= cur_addr + 1'b1;
        end
    end

    a_take_when_valid: assert property (@(posedge clk) disable iff (rst) addr_take |-> addr_valid);

    a_addr_in_region: assert property (@(posedge clk) disable iff (rst)
        playing |-> cur_addr < addr_stop);

endmodule

`default_nettype wire

// File: design/clockdomain_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module clockdomain_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  wire      wr_clk,
    input  wire      wr_rst,
    input  wire      wr_valid,
    output logic     wr_ready,
    input  payload_t wr_data,

    input  wire      rd_clk,
    input  wire      rd_rst,
    output logic     rd_valid,
    input  wire      rd_ready,
    output payload_t rd_data
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t mem [DEPTH];

    logic [PTR_W:0] wr_bin, wr_gray, rd_gray_w1, rd_gray_w2;
    logic [PTR_W:0] rd_bin, rd_gray, wr_gray_r1, wr_gray_r2;
    logic [PTR_W:0] wr_bin_next, rd_bin_next;
    logic [PTR_W:0] wr_level;
    logic           full, empty;
    logic           wr_fire, rd_load;

    function automatic logic [PTR_W:0] to_gray(input logic [PTR_W:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [PTR_W:0] gray_to_bin(input logic [PTR_W:0] g);
        logic [PTR_W:0] b;
        b[PTR_W] = g[PTR_W];
        for (int k = PTR_W - 1; k >= 0; k--) begin
            b[k] = b[k + 1] ^ g[k];
        end
        return b;
    endfunction

    // **********************************************************************
    // Write domain.
    // **********************************************************************

    assign wr_bin_next = wr_bin + 1'b1;
    assign full        = (wr_gray == {~rd_gray_w2[PTR_W:PTR_W-1], rd_gray_w2[PTR_W-2:0]});
    assign wr_ready    = !full;
    assign wr_fire     = wr_valid && wr_ready;

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            {rd_gray_w2, rd_gray_w1} <= {rd_gray_w1, rd_gray};
            if (wr_fire) begin
                wr_bin  <= wr_bin_next;
                wr_gray <= to_gray(wr_bin_next);
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_fire) mem[wr_bin[PTR_W-1:0]] <= wr_data;
    end

    // **********************************************************************
    // Read domain with a first-word-fall-through output register.
    // **********************************************************************

    assign rd_bin_next = rd_bin + 1'b1;
    assign empty       = (rd_gray == wr_gray_r2);
    assign rd_load     = !empty && (!rd_valid || rd_ready);

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
            rd_valid   <= 1'b0;
        end else begin
            {wr_gray_r2, wr_gray_r1} <= {wr_gray_r1, wr_gray};
            if (rd_load) begin
                rd_valid <= 1'b1;
                rd_bin   <= rd_bin_next;
                rd_gray  <= to_gray(rd_bin_next);
            end else if (rd_ready) begin
                rd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_load) rd_data <= mem[rd_bin[PTR_W-1:0]];
    end

    // Seen from the write side, the read pointer lags, so the level must never pass DEPTH.
    assign wr_level = wr_bin - gray_to_bin(rd_gray_w2);

    a_no_overflow: assert property (@(posedge wr_clk) disable iff (wr_rst)
        int'(wr_level) <= DEPTH);

endmodule

`default_nettype wire

// File: design/dram_read_requester.sv
`timescale 1ns/100ps
`default_nettype none

module dram_read_requester
    import sampler_pkg::*;
(
    input  wire                    clk,
    input  wire                    clk_dram_ctrl,
    input  wire                    rst,
    input  wire                    midi_din,

    input  wire [PERIOD_WIDTH-1:0] sample_period,
    input  wire                    sample_load_complete,
    input  wire addr_table_t       addr_offsets,
    input  wire                    addr_offsets_valid,

    output read_req_t              req,
    output logic                   req_valid,
    input  wire                    req_ready
);

    logic       note_on;
    logic [6:0] key;
    logic       setup_complete;

    read_req_t                   addr [INSTRUMENT_COUNT];
    logic [INSTRUMENT_COUNT-1:0] addr_valid;
    logic [INSTRUMENT_COUNT-1:0] addr_take;

    logic [INSTR_ID_WIDTH-1:0] scan_idx;
    read_req_t                 wr_data;
    logic                      wr_valid;
    logic                      wr_ready;

    logic [1:0] rst_dram_sync;

    assign setup_complete = sample_load_complete & addr_offsets_valid;

    midi_processor midi_proc (
        .clk      (clk),
        .rst      (rst),
        .din      (midi_din),
        .note_on  (note_on),
        .key      (key),
        .velocity ()
    );

    for (genvar i = 0; i < INSTRUMENT_COUNT; i++) begin : g_instr
        instrument #(
            .MIDI_KEY(MIDI_KEYS[i])
        ) instr (
            .clk            (clk),
            .rst            (rst),
            .sample_period  (sample_period),
            .note_on        (note_on),
            .key            (key),
            .setup_complete (setup_complete),
            .addr_start     (addr_offsets[i]),
            .addr_stop      (addr_offsets[i+1]),
            .instr_id       (INSTR_ID_WIDTH'(i)),
            .addr           (addr[i]),
            .addr_valid     (addr_valid[i]),
            .addr_take      (addr_take[i])
        );
    end

    // **********************************************************************
    // Round-robin scanner. It stalls as a whole while the FIFO is full.
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_idx  <= '0;
            wr_valid  <= 1'b0;
            addr_take <= '0;
        end else begin
            addr_take <= '0;
            if (wr_ready) begin
                scan_idx <= (scan_idx == INSTR_ID_WIDTH'(INSTRUMENT_COUNT - 1)) ?
                            '0 : scan_idx + 1'b1;
                wr_valid <= addr_valid[scan_idx];
                wr_data  <= addr[scan_idx];
                if (addr_valid[scan_idx]) addr_take[scan_idx] <= 1'b1;  // Frees the instrument.
            end
        end
    end

    // Read side reset, brought into the DRAM controller clock.
    always_ff @(posedge clk_dram_ctrl) begin
        rst_dram_sync <= {rst_dram_sync[0], rst};
    end

    clockdomain_fifo #(
        .payload_t (read_req_t),
        .DEPTH     (FIFO_DEPTH)
    ) req_fifo (
        .wr_clk   (clk),
        .wr_rst   (rst),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_data  (wr_data),
        .rd_clk   (clk_dram_ctrl),
        .rd_rst   (rst_dram_sync[1]),
        .rd_valid (req_valid),
        .rd_ready (req_ready),
        .rd_data  (req)
    );

endmodule

`default_nettype wire

// File: verification/tb_dram_read_requester.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dram_read_requester
    import sampler_pkg::*;
();

    localparam int MSG_CYCLES     = 3 * 10 * MIDI_BIT_CYCLES;  // Three framed bytes.
    localparam int MSG_COUNT      = 12;
    localparam int MAX_SIZE       = 12;
    localparam int SLOW_PERIOD    = 200;
    localparam int QUIET_CYCLES   = 200;
    localparam int SETTLE_CYCLES  = 40;
    localparam int PLAY_CYCLES    = 2 * INSTRUMENT_COUNT * MAX_SIZE * (SLOW_PERIOD + 8);
    localparam int TIMEOUT_CYCLES = MSG_COUNT * MSG_CYCLES + PLAY_CYCLES + 3 * QUIET_CYCLES;

    logic                    clk = 1'b0;
    logic                    clk_dram_ctrl = 1'b0;
    logic                    rst;
    logic                    midi_din;
    logic [PERIOD_WIDTH-1:0] sample_period;
    logic                    sample_load_complete;
    addr_table_t             addr_offsets;
    logic                    addr_offsets_valid;
    read_req_t               req;
    logic                    req_valid;
    logic                    req_ready;

    integer    seed;
    read_req_t exp_q [INSTRUMENT_COUNT][$];  // Expected requests per instrument.
    int        model_count, rx_count, last_count, cycle_count;
    int        error_count, check_count, tests_run, tests_failed, test_errors;
    int        test_num;
    string     test_name;
    logic      interleaved;
    logic [INSTR_ID_WIDTH-1:0] prev_instr;
    logic      backpressure;
    logic      hold_ready;
    logic      ready_pattern [1024];
    int        ready_idx;
    int        perm [INSTRUMENT_COUNT];

    always #10 clk = ~clk;
    always #7 clk_dram_ctrl = ~clk_dram_ctrl;

    dram_read_requester DUT (
        .clk                  (clk),
        .clk_dram_ctrl        (clk_dram_ctrl),
        .rst                  (rst),
        .midi_din             (midi_din),
        .sample_period        (sample_period),
        .sample_load_complete (sample_load_complete),
        .addr_offsets         (addr_offsets),
        .addr_offsets_valid   (addr_offsets_valid),
        .req                  (req),
        .req_valid            (req_valid),
        .req_ready            (req_ready)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    function automatic int region_of(input logic [ADDR_WIDTH-1:0] a);
        int r;
        r = INSTRUMENT_COUNT;
        for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
            if (a >= addr_offsets[i] && a < addr_offsets[i+1]) r = i;
        end
        return r;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < INSTRUMENT_COUNT; i++) n += exp_q[i].size();
        return n;
    endfunction

    // ********************************************************************
    // MIDI serializer and model.
    // ********************************************************************

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // Stop, data, start; sent from bit 0 up.
        for (int i = 0; i < 10; i++) begin
            midi_din = frame[i];
            repeat (MIDI_BIT_CYCLES) @(negedge clk);
        end
    endtask

    task automatic send_note(input logic [6:0] k, input logic [6:0] vel);
        send_byte(8'h90);
        send_byte({1'b0, k});
        send_byte({1'b0, vel});
    endtask

    // Every address of the region, in order, with last on the final one.
    task automatic expect_sample(input int k);
        read_req_t item;
        for (int a = int'(addr_offsets[k]); a < int'(addr_offsets[k+1]); a++) begin
            item.addr  = ADDR_WIDTH'(a);
            item.instr = INSTR_ID_WIDTH'(k);
            item.last  = (a == int'(addr_offsets[k+1]) - 1);
            exp_q[k].push_back(item);
            model_count++;
        end
    endtask

    task automatic play_note(input int k);
        expect_sample(k);
        send_note(MIDI_KEYS[k], 7'(1 + {$random(seed)} % 127));
    endtask

    task automatic pick_period(input int low, input int span);
        sample_period = PERIOD_WIDTH'(low + {$random(seed)} % span);
    endtask

    task automatic wait_for_drain();
        while (pending_count() != 0) @(negedge clk);
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    task automatic start_test(input int n, input string name);
        test_num    = n;
        test_name   = name;
        test_errors = error_count;
    endtask

    task automatic report_test();
        tests_run++;
        if (error_count != test_errors) tests_failed++;
        $display("test %0d (%s): %s", test_num, test_name,
                 (error_count == test_errors) ? "ok" : "error");
    endtask

    // ********************************************************************
    // Read side monitor.
    // ********************************************************************

    always @(posedge clk_dram_ctrl) begin : monitor
        read_req_t expected;
        if (!rst && req_valid === 1'b1 && req_ready) begin
            rx_count++;
            if (req.last) last_count++;
            if (int'(req.instr) >= INSTRUMENT_COUNT || exp_q[req.instr].size() == 0) begin
                $display("Unexpected request at time %0t: addr %0h from instrument %0d",
                         $time, req.addr, req.instr);
                error_count++;
            end else begin
                expected = exp_q[req.instr].pop_front();
                check_value("req.addr", 32'(req.addr), 32'(expected.addr));
                check_value("req.last", 32'(req.last), 32'(expected.last));
                check_value("region of req.addr", 32'(region_of(req.addr)), 32'(req.instr));
                if (req.instr != prev_instr && exp_q[prev_instr].size() != 0) interleaved = 1'b1;
                prev_instr = req.instr;
            end
        end
    end

    always @(negedge clk) begin
        if (hold_ready) begin
            req_ready = 1'b0;
        end else if (backpressure) begin
            req_ready = ready_pattern[ready_idx];
            ready_idx = (ready_idx + 1) % 1024;
        end else begin
            req_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ********************************************************************
    // Test sequence.
    // ********************************************************************

    initial begin : stimulus
        int first_k;
        int tmp;
        int j;
        int rx_before;
        int model_before;
        int last_before;

        seed                 = 32'h661d;
        rst                  = 1'b1;
        midi_din             = 1'b1;
        sample_period        = PERIOD_WIDTH'(4);
        sample_load_complete = 1'b0;
        addr_offsets_valid   = 1'b0;
        req_ready            = 1'b1;
        backpressure         = 1'b0;
        hold_ready           = 1'b0;
        ready_idx            = 0;
        interleaved          = 1'b0;
        prev_instr           = '0;
        {model_count, rx_count, last_count, cycle_count} = '0;
        {error_count, check_count, tests_run, tests_failed} = '0;

        addr_offsets[0] = ADDR_WIDTH'({$random(seed)} % 32'h10_0000);
        for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
            addr_offsets[i+1] = addr_offsets[i] + ADDR_WIDTH'(4 + {$random(seed)} % 9);
        end
        for (int i = 0; i < 1024; i++) ready_pattern[i] = ({$random(seed)} % 8) == 0;
        for (int i = 0; i < INSTRUMENT_COUNT; i++) perm[i] = i;
        for (int i = INSTRUMENT_COUNT - 1; i > 0; i--) begin  // Random key order.
            j       = {$random(seed)} % (i + 1);
            tmp     = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
        first_k = {$random(seed)} % INSTRUMENT_COUNT;

        repeat (3) @(negedge clk);
        rst = 1'b0;
        repeat (10) @(negedge clk);

        start_test(1, "setup gating and one sample");
        sample_load_complete = 1'b1;
        send_note(MIDI_KEYS[0], 7'd100);  // Offsets not valid yet.
        repeat (QUIET_CYCLES) @(negedge clk);
        check_value("requests before setup", 32'(rx_count), 32'd0);
        addr_offsets_valid = 1'b1;
        pick_period(2, 8);
        rx_before   = rx_count;
        last_before = last_count;
        play_note(first_k);
        wait_for_drain();
        check_value("requests", 32'(rx_count - rx_before),
                    32'(addr_offsets[first_k+1] - addr_offsets[first_k]));
        report_test();

        start_test(2, "last flag");
        check_value("last flags", 32'(last_count - last_before), 32'd1);
        report_test();

        start_test(3, "ignored note-ons");
        rx_before = rx_count;
        send_note(MIDI_KEYS[{$random(seed)} % INSTRUMENT_COUNT], 7'd0);
        send_note(7'd61, 7'd100);
        repeat (QUIET_CYCLES) @(negedge clk);
        check_value("requests", 32'(rx_count - rx_before), 32'd0);
        report_test();

        start_test(4, "overlapping instruments");
        pick_period(170, 31);  // Long enough that playbacks overlap.
        interleaved  = 1'b0;
        rx_before    = rx_count;
        model_before = model_count;
        for (int i = 0; i < INSTRUMENT_COUNT; i++) play_note(perm[i]);
        wait_for_drain();
        check_value("requests", 32'(rx_count - rx_before), 32'(model_count - model_before));
        check_value("interleaved", 32'(interleaved), 32'd1);
        report_test();

        start_test(5, "back-pressure");
        pick_period(2, 4);
        hold_ready   = 1'b1;  // At least 16 addresses pile up, so the FIFO fills.
        rx_before    = rx_count;
        model_before = model_count;
        for (int i = 0; i < INSTRUMENT_COUNT; i++) play_note(perm[i]);
        play_note(perm[0]);  // Replays after its first sample has ended.
        repeat (QUIET_CYCLES) @(negedge clk);
        hold_ready   = 1'b0;
        backpressure = 1'b1;
        wait_for_drain();
        backpressure = 1'b0;
        check_value("requests", 32'(rx_count - rx_before), 32'(model_count - model_before));
        report_test();

        start_test(6, "replay");
        pick_period(2, 8);
        rx_before = rx_count;
        play_note(first_k);
        wait_for_drain();
        check_value("requests", 32'(rx_count - rx_before),
                    32'(addr_offsets[first_k+1] - addr_offsets[first_k]));
        check_value("requests in total", 32'(rx_count), 32'(model_count));
        report_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/sampler_pkg.sv
design/midi_processor.sv
design/instrument.sv
design/clockdomain_fifo.sv
design/dram_read_requester.sv
verification/tb_dram_read_requester.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_dram_read_requester -o sim_tb

output=$(./obj_dir/sim_tb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep "Result: PASSED" > /dev/null; then
    exit 0
fi
exit 1
